/* logic/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// alu opcodes
`define EXEC_ALU_ADD    5'd0
`define EXEC_ALU_ADDC   5'd1
`define EXEC_ALU_SUB    5'd2
`define EXEC_ALU_SUBC   5'd3
`define EXEC_ALU_LSL    5'd4
`define EXEC_ALU_LSR    5'd5
`define EXEC_ALU_AND    5'd6
`define EXEC_ALU_XOR    5'd7
`define EXEC_ALU_BIC    5'd8
`define EXEC_ALU_BST    5'd9
`define EXEC_ALU_OR     5'd10
`define EXEC_ALU_COPYB  5'd11
`define EXEC_ALU_CMP    5'd12
`define EXEC_ALU_MOVHI  5'd13
`define EXEC_ALU_ASR    5'd14
`define EXEC_ALU_COPYA  5'd15
`define EXEC_ALU_GCR    5'd16
`define EXEC_ALU_SWI    5'd17
`define EXEC_ALU_RFE    5'd18

// branch conditions, code 0 never taken
`define EXEC_COND_NE     3'd1
`define EXEC_COND_EQ     3'd2
`define EXEC_COND_NC     3'd3
`define EXEC_COND_C      3'd4
`define EXEC_COND_GT     3'd5
`define EXEC_COND_LT     3'd6
`define EXEC_COND_ALWAYS 3'd7

`define EXEC_CLASS_ARITH  2'd0
`define EXEC_CLASS_BRANCH 2'd1
`define EXEC_CLASS_LDST   2'd2
`define EXEC_CLASS_MISC   2'd3

// control register indices
`define EXEC_CR_VECTOR     3'd0
`define EXEC_CR_PSR        3'd1
`define EXEC_CR_SAVED_PSR  3'd2
`define EXEC_CR_FAULT      3'd3
`define EXEC_CR_DATA_FAULT 3'd4

`endif

/* logic/exec_pkg.sv */
package exec_pkg;

	typedef struct packed {
		logic n;
		logic o;
		logic c;
		logic z;
	} exec_flags_t;

	// one decoded instruction as delivered by decode
	typedef struct packed {
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] imm32;
		logic [31:0] pc_plus_4;
		logic [3:0]  rd_sel;
		logic        update_rd;
		logic        update_flags;
		logic        is_call;
		logic        is_swi;
		logic        is_rfe;
		logic        write_cr;
		logic [4:0]  alu_opc;
		logic        op1_ra;
		logic        op1_rb;
		logic        op2_rb;
		logic        mem_load;
		logic        mem_store;
		logic [1:0]  mem_width;
		logic [2:0]  branch_condition;
		logic [1:0]  instr_class;
		logic [2:0]  cr_sel;
	} exec_instr_t;

	typedef struct packed {
		logic        load;
		logic        store;
		logic        wr_en;
		logic [1:0]  width;
		logic [31:0] mar;
		logic [31:0] mdr;
	} exec_mem_req_t;

	typedef struct packed {
		logic        wr_result;
		logic [3:0]  rd_sel;
		logic [31:0] wr_val;
		logic [31:0] alu_out;
		logic [31:0] pc_plus_4;
	} exec_wb_t;

	// control register word, raw or as psr bits
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [27:0] rsvd;
			exec_flags_t flags;
		} psr;
	} exec_cr_word_u;

endpackage

/* logic/exec_alu.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_alu import exec_pkg::*; (
	input  exec_instr_t   instr,
	input  exec_flags_t   flags,
	input  exec_cr_word_u cr_rdata,
	output logic [31:0]   alu_q,
	output logic [31:0]   op2,
	output exec_flags_t   alu_flags
);

	logic [31:0] op1;
	logic        carry;
	logic        neg;
	logic        ovf;

	always_comb begin
		if (instr.op1_ra)
			op1 = instr.ra;
		else if (instr.op1_rb)
			op1 = instr.rb;
		else
			op1 = instr.pc_plus_4; // pc relative
	end

	assign op2 = instr.op2_rb ? instr.rb : instr.imm32;

	always_comb begin
		alu_q = 32'b0;
		carry = 1'b0;
		neg = 1'b0;
		ovf = 1'b0;

		case (instr.alu_opc)
		`EXEC_ALU_ADD:   {carry, alu_q} = {1'b0, op1} + {1'b0, op2};
		`EXEC_ALU_ADDC:  {carry, alu_q} = {1'b0, op1} + {1'b0, op2} + {32'b0, flags.c};
		`EXEC_ALU_SUB:   {carry, alu_q} = {1'b0, op1} - {1'b0, op2};
		`EXEC_ALU_SUBC:  {carry, alu_q} = {1'b0, op1} - {1'b0, op2} - {32'b0, flags.c};
		`EXEC_ALU_LSL:   {carry, alu_q} = {1'b0, op1} << op2[4:0]; // last bit out is carry
		`EXEC_ALU_LSR:   alu_q = op1 >> op2[4:0];
		`EXEC_ALU_AND:   alu_q = op1 & op2;
		`EXEC_ALU_XOR:   alu_q = op1 ^ op2;
		`EXEC_ALU_BIC:   alu_q = op1 & ~(32'd1 << op2[4:0]);
		`EXEC_ALU_BST:   alu_q = op1 | (32'd1 << op2[4:0]);
		`EXEC_ALU_OR:    alu_q = op1 | op2;
		`EXEC_ALU_COPYB: alu_q = op2;
		`EXEC_ALU_CMP: begin
			{carry, alu_q} = {1'b0, op1} - {1'b0, op2};
			// signed overflow when operand signs differ and result takes op2 sign
			ovf = (op1[31] ^ op2[31]) && (alu_q[31] == op2[31]);
			neg = alu_q[31];
		end
		`EXEC_ALU_MOVHI: alu_q = op1 | {16'b0, op2[15:0]};
		`EXEC_ALU_ASR:   alu_q = $signed(op1) >>> op2[4:0];
		`EXEC_ALU_COPYA: alu_q = op1;
		`EXEC_ALU_GCR:   alu_q = cr_rdata.raw;
		`EXEC_ALU_SWI:   alu_q = cr_rdata.raw | 32'h8; // vector table entry 2
		`EXEC_ALU_RFE:   alu_q = cr_rdata.raw;       // return to fault address
		default:         alu_q = 32'b0;
		endcase
	end

	assign alu_flags.n = neg;
	assign alu_flags.o = ovf;
	assign alu_flags.c = carry;
	assign alu_flags.z = op1 == op2;

endmodule

/* logic/exec_branch_cond.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_branch_cond import exec_pkg::*; (
	input  logic [2:0]  branch_condition,
	input  exec_flags_t flags,
	output logic        cond_met
);

	always_comb begin
		case (branch_condition)
		`EXEC_COND_NE:     cond_met = !flags.z;
		`EXEC_COND_EQ:     cond_met = flags.z;
		`EXEC_COND_NC:     cond_met = !flags.c;
		`EXEC_COND_C:      cond_met = flags.c;
		`EXEC_COND_GT:     cond_met = !flags.z && (flags.n == flags.o); // signed
		`EXEC_COND_LT:     cond_met = flags.n != flags.o;
		`EXEC_COND_ALWAYS: cond_met = 1'b1;
		default:           cond_met = 1'b0;
		endcase
	end

endmodule

/* logic/exec_ctrl_regs.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_ctrl_regs import exec_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  exec_instr_t   instr,
	input  exec_flags_t   alu_flags,
	input  logic          data_abort,
	input  logic [31:0]   mar,
	output exec_flags_t   flags,
	output exec_cr_word_u cr_rdata,
	output logic [25:0]   vector_base
);

	logic [25:0]   vector_addr;
	logic [1:0]    saved_psr; // {c, z}
	logic [31:0]   fault_address;
	logic [31:0]   data_fault_address;
	exec_cr_word_u wr_word;
	logic [2:0]    rd_idx;

	assign wr_word.raw = instr.ra;
	assign vector_base = vector_addr;

	function automatic logic cr_write(input exec_instr_t i, input logic [2:0] idx);
		return i.write_cr && i.cr_sel == idx;
	endfunction

	// later assignments win, psr write over rfe over alu update
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else begin
			if (instr.update_flags)
				flags <= alu_flags;
			if (instr.is_rfe) begin
				flags.c <= saved_psr[1];
				flags.z <= saved_psr[0];
			end
			if (cr_write(instr, `EXEC_CR_PSR))
				flags <= wr_word.psr.flags;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			vector_addr <= 26'b0;
		else if (cr_write(instr, `EXEC_CR_VECTOR))
			vector_addr <= instr.ra[31:6]; // table is 64 byte aligned
	end

	always_ff @(posedge clk) begin
		if (rst)
			saved_psr <= 2'b0;
		else if (instr.is_swi)
			saved_psr <= {flags.c, flags.z};
		else if (cr_write(instr, `EXEC_CR_SAVED_PSR))
			saved_psr <= {wr_word.psr.flags.c, wr_word.psr.flags.z};
	end

	always_ff @(posedge clk) begin
		if (rst)
			fault_address <= 32'b0;
		else if (instr.is_swi || data_abort)
			fault_address <= instr.pc_plus_4;
		else if (cr_write(instr, `EXEC_CR_FAULT))
			fault_address <= instr.ra;
	end

	// mar here is the one registered on the previous edge
	always_ff @(posedge clk) begin
		if (rst)
			data_fault_address <= 32'b0;
		else if (data_abort)
			data_fault_address <= mar;
		else if (cr_write(instr, `EXEC_CR_DATA_FAULT))
			data_fault_address <= instr.ra;
	end

	always_comb begin
		case (instr.alu_opc)
		`EXEC_ALU_SWI: rd_idx = `EXEC_CR_VECTOR;
		`EXEC_ALU_RFE: rd_idx = `EXEC_CR_FAULT;
		default:       rd_idx = instr.cr_sel;
		endcase
	end

	always_comb begin
		cr_rdata.raw = 32'b0;
		case (rd_idx)
		`EXEC_CR_VECTOR:     cr_rdata.raw = {vector_addr, 6'b0};
		`EXEC_CR_PSR:        cr_rdata.psr.flags = flags;
		`EXEC_CR_SAVED_PSR:  cr_rdata.raw = {30'b0, saved_psr};
		`EXEC_CR_FAULT:      cr_rdata.raw = fault_address;
		`EXEC_CR_DATA_FAULT: cr_rdata.raw = data_fault_address;
		default:             cr_rdata.raw = 32'b0;
		endcase
	end

endmodule

/* logic/exec_stage.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_stage import exec_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  exec_instr_t   instr,
	input  logic          data_abort,
	output exec_wb_t      wb,
	output exec_mem_req_t mem_req,
	output logic          branch_taken,
	output logic          stall_clear,
	output logic [25:0]   vector_base
);

	logic [31:0]   alu_q;
	logic [31:0]   op2;
	exec_flags_t   alu_flags;
	exec_flags_t   flags;
	exec_cr_word_u cr_rdata;
	logic          cond_met;
	logic          is_branch;

	exec_alu u_alu (
		.instr     (instr),
		.flags     (flags),
		.cr_rdata  (cr_rdata),
		.alu_q     (alu_q),
		.op2       (op2),
		.alu_flags (alu_flags)
	);

	exec_branch_cond u_branch_cond (
		.branch_condition (instr.branch_condition),
		.flags            (flags),
		.cond_met         (cond_met)
	);

	exec_ctrl_regs u_ctrl_regs (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.alu_flags   (alu_flags),
		.data_abort  (data_abort),
		.mar         (mem_req.mar),
		.flags       (flags),
		.cr_rdata    (cr_rdata),
		.vector_base (vector_base)
	);

	assign is_branch = instr.instr_class == `EXEC_CLASS_BRANCH;

	always_ff @(posedge clk) begin
		wb.rd_sel <= instr.rd_sel;
		wb.alu_out <= alu_q;
		wb.pc_plus_4 <= instr.pc_plus_4;
		if (instr.is_call)
			wb.wr_val <= instr.pc_plus_4; // link address
		else if (instr.mem_store)
			wb.wr_val <= op2;
		else
			wb.wr_val <= alu_q;

		if (rst)
			wb.wr_result <= 1'b0;
		else
			wb.wr_result <= instr.update_rd;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			branch_taken <= 1'b0;
			stall_clear <= 1'b0;
		end else begin
			branch_taken <= is_branch && (cond_met || instr.is_swi || instr.is_rfe);
			stall_clear <= is_branch;
		end
	end

	// address and data hold until the next load or store
	always_ff @(posedge clk) begin
		if (instr.mem_load || instr.mem_store) begin
			mem_req.width <= instr.mem_width;
			mem_req.mar <= alu_q;
			mem_req.mdr <= instr.rb;
		end

		if (rst) begin
			mem_req.load <= 1'b0;
			mem_req.store <= 1'b0;
			mem_req.wr_en <= 1'b0;
		end else begin
			mem_req.load <= instr.mem_load;
			mem_req.store <= instr.mem_store;
			mem_req.wr_en <= instr.mem_store;
		end
	end

endmodule

/* dv/exec_stage_checker.sv */
`timescale 1ns/1ps

module exec_stage_checker (
	input logic clk,
	input logic rst,
	input logic branch_taken,
	input logic stall_clear,
	input logic wr_en,
	input logic store,
	input logic wr_result
);

	// strobes are cleared one edge after reset
	assert property (@(posedge clk) $past(rst) |-> !branch_taken && !wr_en && !wr_result)
		else $error("branch_taken, wr_en or wr_result high after reset");

	assert property (@(posedge clk) disable iff (rst) wr_en == store)
		else $error("wr_en differs from store");

	assert property (@(posedge clk) disable iff (rst) branch_taken |-> stall_clear)
		else $error("branch_taken without stall_clear");

endmodule

/* dv/exec_ref_model.svh */
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

`include "exec_settings.svh"

exec_flags_t   ref_flags;
logic [25:0]   ref_vector;
logic [1:0]    ref_saved; // {c, z}
logic [31:0]   ref_fault;
logic [31:0]   ref_data_fault;

// what the dut should show after the next edge
exec_wb_t      exp_wb;
exec_mem_req_t exp_mem;
logic          exp_taken;
logic          exp_stall;

task automatic reset_model();
	ref_flags = '0;
	ref_vector = 26'b0;
	ref_saved = 2'b0;
	ref_fault = 32'b0;
	ref_data_fault = 32'b0;
	exp_wb = '0;
	exp_mem = '0;
	exp_taken = 1'b0;
	exp_stall = 1'b0;
endtask

function automatic logic [31:0] read_cr(input logic [2:0] idx);
	case (idx)
	`EXEC_CR_VECTOR:     return {ref_vector, 6'b0};
	`EXEC_CR_PSR:        return {28'b0, ref_flags};
	`EXEC_CR_SAVED_PSR:  return {30'b0, ref_saved};
	`EXEC_CR_FAULT:      return ref_fault;
	`EXEC_CR_DATA_FAULT: return ref_data_fault;
	default:             return 32'b0;
	endcase
endfunction

function automatic logic branch_cond_holds(input logic [2:0] cc, input exec_flags_t f);
	case (cc)
	`EXEC_COND_NE:     return !f.z;
	`EXEC_COND_EQ:     return f.z;
	`EXEC_COND_NC:     return !f.c;
	`EXEC_COND_C:      return f.c;
	`EXEC_COND_GT:     return !f.z && f.n == f.o;
	`EXEC_COND_LT:     return f.n != f.o;
	`EXEC_COND_ALWAYS: return 1'b1;
	default:           return 1'b0;
	endcase
endfunction

task automatic alu_ref(input exec_instr_t i, output logic [31:0] q, output logic [31:0] b,
		output exec_flags_t f);
	logic [31:0] a;
	logic [31:0] sra;
	logic [32:0] wide; // bit 32 is carry or borrow
	logic [4:0]  sh;
	a = i.op1_ra ? i.ra : (i.op1_rb ? i.rb : i.pc_plus_4);
	b = i.op2_rb ? i.rb : i.imm32;
	sh = b[4:0];
	sra = $signed(a) >>> sh;
	f = '0;
	case (i.alu_opc)
	`EXEC_ALU_ADD:   wide = {1'b0, a} + {1'b0, b};
	`EXEC_ALU_ADDC:  wide = {1'b0, a} + {1'b0, b} + {32'b0, ref_flags.c};
	`EXEC_ALU_SUB,
	`EXEC_ALU_CMP:   wide = {1'b0, a} - {1'b0, b};
	`EXEC_ALU_SUBC:  wide = {1'b0, a} - {1'b0, b} - {32'b0, ref_flags.c};
	`EXEC_ALU_LSL:   wide = {1'b0, a} << sh;
	`EXEC_ALU_LSR:   wide = {1'b0, a >> sh};
	`EXEC_ALU_AND:   wide = {1'b0, a & b};
	`EXEC_ALU_XOR:   wide = {1'b0, a ^ b};
	`EXEC_ALU_BIC:   wide = {1'b0, a & ~(32'd1 << sh)};
	`EXEC_ALU_BST:   wide = {1'b0, a | (32'd1 << sh)};
	`EXEC_ALU_OR:    wide = {1'b0, a | b};
	`EXEC_ALU_COPYB: wide = {1'b0, b};
	`EXEC_ALU_MOVHI: wide = {1'b0, a | {16'b0, b[15:0]}};
	`EXEC_ALU_ASR:   wide = {1'b0, sra};
	`EXEC_ALU_COPYA: wide = {1'b0, a};
	`EXEC_ALU_GCR:   wide = {1'b0, read_cr(i.cr_sel)};
	`EXEC_ALU_SWI:   wide = {1'b0, read_cr(`EXEC_CR_VECTOR) + 32'd8};
	`EXEC_ALU_RFE:   wide = {1'b0, ref_fault};
	default:         wide = 33'b0;
	endcase
	q = wide[31:0];
	f.c = wide[32];
	f.z = a == b;
	if (i.alu_opc == `EXEC_ALU_CMP) begin
		f.n = q[31];
		f.o = (a[31] != b[31]) && (q[31] != a[31]);
	end
endtask

// outputs from the state before the edge, then the state update at the edge
task automatic step_model(input exec_instr_t i, input logic abort);
	logic [31:0] q;
	logic [31:0] b;
	logic [31:0] prev_mar;
	exec_flags_t f;
	exec_flags_t next_flags;
	alu_ref(i, q, b, f);
	exp_wb.wr_result = i.update_rd;
	exp_wb.rd_sel = i.rd_sel;
	exp_wb.alu_out = q;
	exp_wb.pc_plus_4 = i.pc_plus_4;
	exp_wb.wr_val = i.is_call ? i.pc_plus_4 : (i.mem_store ? b : q);
	exp_stall = i.instr_class == `EXEC_CLASS_BRANCH;
	exp_taken = exp_stall && (branch_cond_holds(i.branch_condition, ref_flags) ||
		i.is_swi || i.is_rfe);
	prev_mar = exp_mem.mar;
	if (i.mem_load || i.mem_store) begin
		exp_mem.width = i.mem_width;
		exp_mem.mar = q;
		exp_mem.mdr = i.rb;
	end
	exp_mem.load = i.mem_load;
	exp_mem.store = i.mem_store;
	exp_mem.wr_en = i.mem_store;

	next_flags = ref_flags;
	if (i.update_flags)
		next_flags = f;
	if (i.is_rfe) begin
		next_flags.c = ref_saved[1];
		next_flags.z = ref_saved[0];
	end
	if (i.write_cr && i.cr_sel == `EXEC_CR_PSR)
		next_flags = exec_flags_t'(i.ra[3:0]);
	if (i.is_swi)
		ref_saved = {ref_flags.c, ref_flags.z};
	else if (i.write_cr && i.cr_sel == `EXEC_CR_SAVED_PSR)
		ref_saved = i.ra[1:0];
	if (i.is_swi || abort)
		ref_fault = i.pc_plus_4;
	else if (i.write_cr && i.cr_sel == `EXEC_CR_FAULT)
		ref_fault = i.ra;
	if (abort)
		ref_data_fault = prev_mar;
	else if (i.write_cr && i.cr_sel == `EXEC_CR_DATA_FAULT)
		ref_data_fault = i.ra;
	if (i.write_cr && i.cr_sel == `EXEC_CR_VECTOR)
		ref_vector = i.ra[31:6];
	ref_flags = next_flags;
endtask

`endif

/* dv/exec_stage_tb.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_stage_tb import exec_pkg::*;;

	localparam int NUM_CYCLES = 5000;
	localparam int RESET_CYCLES = 16;
	localparam int CAT_ALU = 0;
	localparam int CAT_WB = 1;
	localparam int CAT_BRANCH = 2;
	localparam int CAT_MEM = 3;
	localparam int CAT_CR = 4;

	logic          clk;
	logic          rst;
	exec_instr_t   instr;
	logic          data_abort;
	exec_wb_t      wb;
	exec_mem_req_t mem_req;
	logic          branch_taken;
	logic          stall_clear;
	logic [25:0]   vector_base;
	int            err_count [5];
	logic [4:0]    last_opc;

	`include "exec_ref_model.svh"

	exec_stage uut (
		.clk          (clk),
		.rst          (rst),
		.instr        (instr),
		.data_abort   (data_abort),
		.wb           (wb),
		.mem_req      (mem_req),
		.branch_taken (branch_taken),
		.stall_clear  (stall_clear),
		.vector_base  (vector_base)
	);

	bind exec_stage exec_stage_checker u_checker (
		.clk          (clk),
		.rst          (rst),
		.branch_taken (branch_taken),
		.stall_clear  (stall_clear),
		.wr_en        (mem_req.wr_en),
		.store        (mem_req.store),
		.wr_result    (wb.wr_result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#((NUM_CYCLES + RESET_CYCLES + 100) * 4);
		$display("timeout: run did not finish within %0d cycles", NUM_CYCLES + RESET_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic exec_instr_t random_instr();
		exec_instr_t i;
		logic [31:0] r;
		logic [31:0] s;
		r = $urandom();
		s = $urandom();
		i = '0;
		i.ra = $urandom();
		i.rb = (s[31:30] == 2'd0) ? i.ra : $urandom(); // equal operands now and then
		i.imm32 = (s[29:27] == 3'd0) ? i.ra : $urandom();
		i.pc_plus_4 = $urandom() & 32'hffff_fffc;
		i.rd_sel = r[3:0];
		i.update_rd = r[4];
		i.update_flags = r[5];
		i.is_call = r[8:6] == 3'd0;
		i.op1_ra = r[9];
		i.op1_rb = r[10];
		i.op2_rb = r[11];
		i.mem_width = r[13:12];
		i.branch_condition = r[16:14];
		i.instr_class = r[18:17];
		i.mem_load = r[20:19] == 2'd1;
		i.mem_store = r[20:19] == 2'd2;
		i.write_cr = r[24:21] == 4'd0;
		i.cr_sel = (r[28:25] == 4'd0) ? r[31:29] : r[31:29] % 3'd5;
		i.alu_opc = (s[3:0] == 4'd0) ? 5'd19 + {2'b0, s[6:4]} : s[11:7] % 5'd19;
		if (s[14:12] == 3'd0)
			i.alu_opc = `EXEC_ALU_GCR;
		if (s[19:15] == 5'd0) begin
			i.is_swi = 1'b1;
			i.alu_opc = `EXEC_ALU_SWI;
			i.instr_class = `EXEC_CLASS_BRANCH;
		end else if (s[24:20] == 5'd0) begin
			i.is_rfe = 1'b1;
			i.alu_opc = `EXEC_ALU_RFE;
			i.instr_class = `EXEC_CLASS_BRANCH;
		end
		return i;
	endfunction

	task automatic check_value(input int cat, input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			err_count[cat]++;
			$display("Error %s at %0t: expected %h actual %h", name, $time, expected, actual);
		end
	endtask

	task automatic check_outputs();
		int alu_cat;
		// gcr, swi and rfe results come from the control registers
		alu_cat = (last_opc >= `EXEC_ALU_GCR && last_opc <= `EXEC_ALU_RFE) ? CAT_CR : CAT_ALU;
		check_value(alu_cat, "alu_out", exp_wb.alu_out, wb.alu_out);
		check_value(CAT_WB, "wr_val", exp_wb.wr_val, wb.wr_val);
		check_value(CAT_WB, "wr_result", 32'(exp_wb.wr_result), 32'(wb.wr_result));
		check_value(CAT_WB, "rd_sel", 32'(exp_wb.rd_sel), 32'(wb.rd_sel));
		check_value(CAT_WB, "wb_pc_plus_4", exp_wb.pc_plus_4, wb.pc_plus_4);
		check_value(CAT_BRANCH, "branch_taken", 32'(exp_taken), 32'(branch_taken));
		check_value(CAT_BRANCH, "stall_clear", 32'(exp_stall), 32'(stall_clear));
		check_value(CAT_MEM, "mem_load", 32'(exp_mem.load), 32'(mem_req.load));
		check_value(CAT_MEM, "mem_store", 32'(exp_mem.store), 32'(mem_req.store));
		check_value(CAT_MEM, "mem_wr_en", 32'(exp_mem.wr_en), 32'(mem_req.wr_en));
		check_value(CAT_MEM, "mem_width", 32'(exp_mem.width), 32'(mem_req.width));
		check_value(CAT_MEM, "mem_mar", exp_mem.mar, mem_req.mar);
		check_value(CAT_MEM, "mem_mdr", exp_mem.mdr, mem_req.mdr);
		check_value(CAT_CR, "vector_base", 32'(ref_vector), 32'(vector_base));
	endtask

	initial begin
		logic [31:0] seed_draw;
		exec_instr_t next_instr;
		logic        abort;
		int          total;
		int          k;
		seed_draw = $urandom(32'hc8f22e12);
		err_count = '{default: 0};
		rst = 1'b1;
		data_abort = 1'b0;
		instr = '0;
		instr.mem_load = 1'b1; // load from address 0 so mar and mdr start known
		last_opc = 5'd0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		for (k = 0; k < NUM_CYCLES; k++) begin
			next_instr = random_instr();
			abort = $urandom_range(0, 31) == 0;
			instr = next_instr;
			data_abort = abort;
			last_opc = next_instr.alu_opc;
			step_model(next_instr, abort);
			@(posedge clk);
			#1;
			check_outputs();
		end
		total = 0;
		for (k = 0; k < 5; k++)
			total += err_count[k];
		$display("errors: alu %0d wb %0d branch %0d mem %0d cr %0d total %0d",
			err_count[CAT_ALU], err_count[CAT_WB], err_count[CAT_BRANCH],
			err_count[CAT_MEM], err_count[CAT_CR], total);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* exec_stage.f */
+incdir+logic
+incdir+dv
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_branch_cond.sv
logic/exec_ctrl_regs.sv
logic/exec_stage.sv
dv/exec_stage_checker.sv
dv/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f exec_stage.f --top-module exec_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vexec_stage_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
